// File: source/ctrl_decode_pkg.sv
`default_nettype none
// ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
// RV32IM decode types: opcodes, instruction field views, the main and
// ALU control words, and the ALU operation codes
// ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
package ctrl_decode_pkg;

    typedef logic [31:0] xlen_t;                // raw instruction word

    typedef enum logic [6:0] {
        OPC_LUI    = 7'b0110111,
        OPC_AUIPC  = 7'b0010111,
        OPC_JAL    = 7'b1101111,
        OPC_JALR   = 7'b1100111,
        OPC_BRANCH = 7'b1100011,
        OPC_LOAD   = 7'b0000011,
        OPC_STORE  = 7'b0100011,
        OPC_OP_IMM = 7'b0010011,
        OPC_OP     = 7'b0110011
    } opcode_e;

    // one class per decoded opcode, in the order of the old instr_type code
    typedef enum logic [3:0] {
        CLASS_LUI    = 4'd0,
        CLASS_AUIPC  = 4'd1,
        CLASS_JAL    = 4'd2,
        CLASS_JALR   = 4'd3,
        CLASS_BRANCH = 4'd4,
        CLASS_LOAD   = 4'd5,
        CLASS_STORE  = 4'd6,
        CLASS_OP_IMM = 4'd7,
        CLASS_OP     = 4'd8,
        CLASS_NONE   = 4'd15                    // opcode not handled here
    } instr_class_e;

    typedef struct packed {
        logic [6:0] funct7;
        logic [4:0] rs2;
        logic [4:0] rs1;
        logic [2:0] funct3;
        logic [4:0] rd;
        logic [6:0] opcode;
    } r_fmt_t;

    typedef struct packed {
        logic [11:0] imm;
        logic [4:0]  rs1;
        logic [2:0]  funct3;
        logic [4:0]  rd;
        logic [6:0]  opcode;
    } i_fmt_t;

    // shift immediates carry funct7 in imm[11:5], so both views are needed
    typedef union packed {
        r_fmt_t r;
        i_fmt_t i;
    } instr_u;

    localparam logic [6:0] F7_BASE   = 7'b0000000;
    localparam logic [6:0] F7_ALT    = 7'b0100000;  // sub, sra
    localparam logic [6:0] F7_MULDIV = 7'b0000001;  // M extension

    typedef enum logic [1:0] {
        WB_IMM     = 2'b00,
        WB_ALU_MEM = 2'b01,
        WB_PC4     = 2'b10
    } wb_sel_e;

    typedef enum logic [2:0] {
        IMM_B  = 3'b000,
        IMM_IS = 3'b001,                        // load/store offset
        IMM_I  = 3'b010,
        IMM_U  = 3'b011,
        IMM_J  = 3'b100
    } imm_sel_e;

    typedef enum logic [4:0] {
        ADD    = 5'd0,
        SUB    = 5'd1,
        AND    = 5'd2,
        OR     = 5'd3,
        XOR    = 5'd4,
        SLL    = 5'd5,
        SRL    = 5'd6,
        SRA    = 5'd7,
        MUL    = 5'd8,
        MULH   = 5'd9,
        MULHSU = 5'd10,
        MULHU  = 5'd11,
        DIV    = 5'd12,
        DIVU   = 5'd13,
        REM    = 5'd14,
        REMU   = 5'd15,
        SLT    = 5'd16,
        SLTU   = 5'd17
    } alu_op_e;

    typedef struct packed {
        logic    reg_write;
        logic    mem_read;
        logic    mem_write;
        logic    branch;
        logic    jump;
        wb_sel_e wb_sel;
    } main_ctrl_t;

    typedef struct packed {
        alu_op_e  alu_op;
        logic     op_a_pc;                      // 1 selects pc as operand a
        imm_sel_e imm_sel;
        logic     store_sel;
        logic     result_sel;
    } alu_ctrl_t;

    // inactive words, loaded on reset and when no instruction is offered
    localparam main_ctrl_t MAIN_CTRL_IDLE = '{
        reg_write: 1'b0, mem_read: 1'b0, mem_write: 1'b0,
        branch: 1'b0, jump: 1'b0, wb_sel: WB_IMM
    };

    localparam alu_ctrl_t ALU_CTRL_IDLE = '{
        alu_op: ADD, op_a_pc: 1'b0, imm_sel: IMM_B,
        store_sel: 1'b0, result_sel: 1'b0
    };

endpackage
`default_nettype wire

// File: source/main_decoder.sv
`timescale 1ns/10ps
`default_nettype none
// ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
// Main decoder: opcode to instruction class (same cycle) and to the
// registered main control word and valid flag (one cycle later)
// ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
module main_decoder (
    input  logic                          clk,
    input  logic                          rst,
    input  logic                          instr_valid,
    input  ctrl_decode_pkg::instr_u       instr,
    output ctrl_decode_pkg::instr_class_e instr_class,
    output ctrl_decode_pkg::main_ctrl_t   main_ctrl,
    output logic                          ctrl_valid
);

    ctrl_decode_pkg::main_ctrl_t main_next;     // decoded word before the register

    always_comb begin
        main_next   = ctrl_decode_pkg::MAIN_CTRL_IDLE;
        instr_class = ctrl_decode_pkg::CLASS_NONE;
        case (instr.r.opcode)
            ctrl_decode_pkg::OPC_LUI: begin
                instr_class         = ctrl_decode_pkg::CLASS_LUI;
                main_next.reg_write = 1'b1;
                main_next.wb_sel    = ctrl_decode_pkg::WB_IMM;     // immediate straight to rd
            end
            ctrl_decode_pkg::OPC_AUIPC: begin
                instr_class         = ctrl_decode_pkg::CLASS_AUIPC;
                main_next.reg_write = 1'b1;
                main_next.wb_sel    = ctrl_decode_pkg::WB_ALU_MEM;
            end
            ctrl_decode_pkg::OPC_JAL: begin
                instr_class         = ctrl_decode_pkg::CLASS_JAL;
                main_next.reg_write = 1'b1;
                main_next.jump      = 1'b1;
                main_next.wb_sel    = ctrl_decode_pkg::WB_PC4;     // link address
            end
            ctrl_decode_pkg::OPC_JALR: begin
                instr_class         = ctrl_decode_pkg::CLASS_JALR;
                main_next.reg_write = 1'b1;
                main_next.jump      = 1'b1;
                main_next.wb_sel    = ctrl_decode_pkg::WB_PC4;
            end
            ctrl_decode_pkg::OPC_BRANCH: begin
                instr_class         = ctrl_decode_pkg::CLASS_BRANCH;
                main_next.branch    = 1'b1;
                main_next.wb_sel    = ctrl_decode_pkg::WB_ALU_MEM;
            end
            ctrl_decode_pkg::OPC_LOAD: begin
                instr_class         = ctrl_decode_pkg::CLASS_LOAD;
                main_next.reg_write = 1'b1;
                main_next.mem_read  = 1'b1;
                main_next.wb_sel    = ctrl_decode_pkg::WB_ALU_MEM;
            end
            ctrl_decode_pkg::OPC_STORE: begin
                instr_class         = ctrl_decode_pkg::CLASS_STORE;
                main_next.mem_write = 1'b1;
                main_next.wb_sel    = ctrl_decode_pkg::WB_ALU_MEM;
            end
            ctrl_decode_pkg::OPC_OP_IMM: begin
                instr_class         = ctrl_decode_pkg::CLASS_OP_IMM;
                main_next.reg_write = 1'b1;
                main_next.wb_sel    = ctrl_decode_pkg::WB_ALU_MEM;
            end
            ctrl_decode_pkg::OPC_OP: begin
                instr_class         = ctrl_decode_pkg::CLASS_OP;
                main_next.reg_write = 1'b1;
                main_next.wb_sel    = ctrl_decode_pkg::WB_ALU_MEM;
            end
            default: begin
                // system, fence, atomics and anything unknown stay inactive
                instr_class = ctrl_decode_pkg::CLASS_NONE;
                main_next   = ctrl_decode_pkg::MAIN_CTRL_IDLE;
            end
        endcase
    end

    always_ff @(posedge clk) begin
        if (rst) begin
            main_ctrl  <= ctrl_decode_pkg::MAIN_CTRL_IDLE;
            ctrl_valid <= 1'b0;
        end else begin
            ctrl_valid <= instr_valid;
            if (instr_valid) begin
                main_ctrl <= main_next;
            end else begin
                main_ctrl <= ctrl_decode_pkg::MAIN_CTRL_IDLE;  // bubble
            end
        end
    end

endmodule
`default_nettype wire

// File: source/alu_op_decoder.sv
`timescale 1ns/10ps
`default_nettype none
// ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
// ALU op decoder: class, funct3 and funct7 to the registered ALU
// operation and datapath operand selects
// ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
module alu_op_decoder (
    input  logic                          clk,
    input  logic                          rst,
    input  logic                          instr_valid,
    input  ctrl_decode_pkg::instr_u       instr,
    input  ctrl_decode_pkg::instr_class_e instr_class,
    output ctrl_decode_pkg::alu_ctrl_t    alu_ctrl
);

    ctrl_decode_pkg::alu_ctrl_t alu_next;       // decoded word before the register

    // immediate ops; only the shifts look at funct7, and only at bit 5
    function automatic ctrl_decode_pkg::alu_op_e op_imm_alu(
        input logic [2:0] funct3,
        input logic [6:0] funct7
    );
        logic alt;
        alt = (funct7 & ctrl_decode_pkg::F7_ALT) != ctrl_decode_pkg::F7_BASE;
        case (funct3)
            3'b000:  return ctrl_decode_pkg::ADD;
            3'b001:  return ctrl_decode_pkg::SLL;
            3'b010:  return ctrl_decode_pkg::SLT;
            3'b011:  return ctrl_decode_pkg::SLTU;
            3'b100:  return ctrl_decode_pkg::XOR;
            3'b101:  return alt ? ctrl_decode_pkg::SRA : ctrl_decode_pkg::SRL;
            3'b110:  return ctrl_decode_pkg::OR;
            default: return ctrl_decode_pkg::AND;
        endcase
    endfunction

    // register-register ops, base set or M extension by funct7
    function automatic ctrl_decode_pkg::alu_op_e op_reg_alu(
        input logic [2:0] funct3,
        input logic [6:0] funct7
    );
        logic alt;
        alt = (funct7 == ctrl_decode_pkg::F7_ALT);
        if (funct7 == ctrl_decode_pkg::F7_MULDIV) begin
            case (funct3)
                3'b000:  return ctrl_decode_pkg::MUL;
                3'b001:  return ctrl_decode_pkg::MULH;
                3'b010:  return ctrl_decode_pkg::MULHSU;
                3'b011:  return ctrl_decode_pkg::MULHU;
                3'b100:  return ctrl_decode_pkg::DIV;
                3'b101:  return ctrl_decode_pkg::DIVU;
                3'b110:  return ctrl_decode_pkg::REM;
                default: return ctrl_decode_pkg::REMU;
            endcase
        end
        case (funct3)
            3'b000:  return alt ? ctrl_decode_pkg::SUB : ctrl_decode_pkg::ADD;
            3'b001:  return ctrl_decode_pkg::SLL;
            3'b010:  return ctrl_decode_pkg::SLT;
            3'b011:  return ctrl_decode_pkg::SLTU;
            3'b100:  return ctrl_decode_pkg::XOR;
            3'b101:  return alt ? ctrl_decode_pkg::SRA : ctrl_decode_pkg::SRL;
            3'b110:  return ctrl_decode_pkg::OR;
            default: return ctrl_decode_pkg::AND;
        endcase
    endfunction

    always_comb begin
        alu_next = ctrl_decode_pkg::ALU_CTRL_IDLE;
        case (instr_class)
            ctrl_decode_pkg::CLASS_LUI: begin
                alu_next.imm_sel = ctrl_decode_pkg::IMM_U;     // alu result unused
            end
            ctrl_decode_pkg::CLASS_AUIPC: begin
                alu_next.op_a_pc = 1'b1;
                alu_next.imm_sel = ctrl_decode_pkg::IMM_U;
            end
            ctrl_decode_pkg::CLASS_JAL: begin
                alu_next.op_a_pc = 1'b1;
                alu_next.imm_sel = ctrl_decode_pkg::IMM_J;
            end
            ctrl_decode_pkg::CLASS_JALR: begin
                alu_next.imm_sel = ctrl_decode_pkg::IMM_J;     // target from rs1
            end
            ctrl_decode_pkg::CLASS_BRANCH: begin
                alu_next.alu_op     = ctrl_decode_pkg::SUB;    // compare by subtraction
                alu_next.imm_sel    = ctrl_decode_pkg::IMM_B;
                alu_next.result_sel = 1'b1;
            end
            ctrl_decode_pkg::CLASS_LOAD: begin
                alu_next.imm_sel    = ctrl_decode_pkg::IMM_IS;
                alu_next.result_sel = 1'b1;
            end
            ctrl_decode_pkg::CLASS_STORE: begin
                alu_next.imm_sel    = ctrl_decode_pkg::IMM_IS;
                alu_next.store_sel  = 1'b1;
                alu_next.result_sel = 1'b1;
            end
            ctrl_decode_pkg::CLASS_OP_IMM: begin
                alu_next.alu_op     = op_imm_alu(instr.i.funct3, instr.r.funct7);
                alu_next.op_a_pc    = 1'b1;                    // mux value kept from old datapath
                alu_next.imm_sel    = ctrl_decode_pkg::IMM_I;
                alu_next.result_sel = 1'b1;
            end
            ctrl_decode_pkg::CLASS_OP: begin
                alu_next.alu_op     = op_reg_alu(instr.r.funct3, instr.r.funct7);
                alu_next.result_sel = 1'b1;
            end
            default: begin
                alu_next = ctrl_decode_pkg::ALU_CTRL_IDLE;     // unlisted opcode
            end
        endcase
    end

    always_ff @(posedge clk) begin
        if (rst) begin
            alu_ctrl <= ctrl_decode_pkg::ALU_CTRL_IDLE;
        end else if (instr_valid) begin
            alu_ctrl <= alu_next;
        end else begin
            alu_ctrl <= ctrl_decode_pkg::ALU_CTRL_IDLE;        // bubble
        end
    end

endmodule
`default_nettype wire

// File: source/control_unit.sv
`timescale 1ns/10ps
`default_nettype none
// ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
// Control unit: registered RV32IM decode stage, one cycle of latency
// ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
module control_unit (
    input  logic                        clk,
    input  logic                        rst,
    input  logic                        instr_valid,
    input  ctrl_decode_pkg::instr_u     instr,
    output ctrl_decode_pkg::main_ctrl_t main_ctrl,
    output ctrl_decode_pkg::alu_ctrl_t  alu_ctrl,
    output logic                        ctrl_valid
);

    ctrl_decode_pkg::instr_class_e instr_class;  // same-cycle class from the opcode

    main_decoder u_main_decoder (
        .clk         (clk),
        .rst         (rst),
        .instr_valid (instr_valid),
        .instr       (instr),
        .instr_class (instr_class),
        .main_ctrl   (main_ctrl),
        .ctrl_valid  (ctrl_valid)
    );

    alu_op_decoder u_alu_op_decoder (
        .clk         (clk),
        .rst         (rst),
        .instr_valid (instr_valid),
        .instr       (instr),
        .instr_class (instr_class),
        .alu_ctrl    (alu_ctrl)
    );

endmodule
`default_nettype wire

// File: tests/ref_decode.svh
`ifndef REF_DECODE_SVH
`define REF_DECODE_SVH
// ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
// Reference decoder: expected main and ALU control words of one
// RV32IM instruction, taken from the ISA opcode and funct encodings
// ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~

// base integer op by funct3; sub and sra only where the caller allows them
function automatic ctrl_decode_pkg::alu_op_e base_op(
    input logic [2:0] f3,
    input logic       use_sub,
    input logic       use_sra
);
    case (f3)
        3'd0:    return use_sub ? ctrl_decode_pkg::SUB : ctrl_decode_pkg::ADD;
        3'd1:    return ctrl_decode_pkg::SLL;
        3'd2:    return ctrl_decode_pkg::SLT;
        3'd3:    return ctrl_decode_pkg::SLTU;
        3'd4:    return ctrl_decode_pkg::XOR;
        3'd5:    return use_sra ? ctrl_decode_pkg::SRA : ctrl_decode_pkg::SRL;
        3'd6:    return ctrl_decode_pkg::OR;
        default: return ctrl_decode_pkg::AND;
    endcase
endfunction

function automatic void ref_decode(
    input  logic [31:0]                 word,
    output ctrl_decode_pkg::main_ctrl_t m,
    output ctrl_decode_pkg::alu_ctrl_t  a
);
    logic [6:0] opc;
    logic [2:0] f3;
    logic [6:0] f7;
    opc = word[6:0];
    f3  = word[14:12];
    f7  = word[31:25];
    m   = '0;                                   // inactive word, alu op ADD
    a   = '0;
    // every decoded class except lui writes back through the alu/mem path
    if (opc != 7'b0110111) begin
        m.wb_sel = ctrl_decode_pkg::WB_ALU_MEM;
    end
    case (opc)
        7'b0110111: begin                       // lui
            m.reg_write = 1'b1;
            a.imm_sel   = ctrl_decode_pkg::IMM_U;
        end
        7'b0010111: begin                       // auipc
            m.reg_write = 1'b1;
            a.op_a_pc   = 1'b1;
            a.imm_sel   = ctrl_decode_pkg::IMM_U;
        end
        7'b1101111, 7'b1100111: begin           // jal, jalr
            m.reg_write = 1'b1;
            m.jump      = 1'b1;
            m.wb_sel    = ctrl_decode_pkg::WB_PC4;
            a.op_a_pc   = opc[3];               // set for jal only
            a.imm_sel   = ctrl_decode_pkg::IMM_J;
        end
        7'b1100011: begin                       // branches
            m.branch     = 1'b1;
            a.alu_op     = ctrl_decode_pkg::SUB;
            a.result_sel = 1'b1;
        end
        7'b0000011: begin                       // loads
            m.reg_write  = 1'b1;
            m.mem_read   = 1'b1;
            a.imm_sel    = ctrl_decode_pkg::IMM_IS;
            a.result_sel = 1'b1;
        end
        7'b0100011: begin                       // stores
            m.mem_write  = 1'b1;
            a.imm_sel    = ctrl_decode_pkg::IMM_IS;
            a.store_sel  = 1'b1;
            a.result_sel = 1'b1;
        end
        7'b0010011: begin                       // op-imm
            m.reg_write  = 1'b1;
            a.alu_op     = base_op(f3, 1'b0, f7[5]);
            a.op_a_pc    = 1'b1;
            a.imm_sel    = ctrl_decode_pkg::IMM_I;
            a.result_sel = 1'b1;
        end
        7'b0110011: begin                       // op
            m.reg_write  = 1'b1;
            a.result_sel = 1'b1;
            if (f7 == 7'b0000001) begin
                a.alu_op = ctrl_decode_pkg::alu_op_e'(5'd8 + {2'b00, f3});  // mul..remu
            end else begin
                a.alu_op = base_op(f3, f7 == 7'b0100000, f7 == 7'b0100000);
            end
        end
        default: begin
            m = '0;
            a = '0;
        end
    endcase
endfunction

`endif

// File: tests/tb_control_unit.sv
`timescale 1ns/10ps
`default_nettype none
// ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
// Testbench for the control unit
// drives directed and random instructions and compares each result
// with the reference decoder one cycle later
// ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
module tb_control_unit;

    localparam int WAIT_LIMIT = 8;              // cycles allowed per wait

    logic                        clk;
    logic                        rst;
    logic                        instr_valid;
    ctrl_decode_pkg::instr_u     instr;
    ctrl_decode_pkg::main_ctrl_t main_ctrl;
    ctrl_decode_pkg::alu_ctrl_t  alu_ctrl;
    logic                        ctrl_valid;

    ctrl_decode_pkg::main_ctrl_t exp_main;      // one-entry pipeline model
    ctrl_decode_pkg::alu_ctrl_t  exp_alu;
    logic                        exp_valid;
    logic                        armed = 1'b0;  // set after the first edge

    integer seed = 32'h1c69_f019;
    int     errors = 0;                         // from the comparing process
    int     check_errors = 0;                   // from the stimulus process
    int     timeouts = 0;
    int     sent = 0;
    int     seen = 0;

    `include "ref_decode.svh"

    control_unit u_control_unit (
        .clk         (clk),
        .rst         (rst),
        .instr_valid (instr_valid),
        .instr       (instr),
        .main_ctrl   (main_ctrl),
        .alu_ctrl    (alu_ctrl),
        .ctrl_valid  (ctrl_valid)
    );

    initial begin
        clk = 1'b0;
        forever #20 clk = ~clk;
    end

    initial begin
        #240000;
        $display("Timeout: the simulation did not finish within 6000 cycles");
        $display("Test failed");
        $finish;
    end

    // expected outputs one cycle after the inputs are sampled
    always @(posedge clk) begin : model
        ctrl_decode_pkg::main_ctrl_t m;
        ctrl_decode_pkg::alu_ctrl_t  a;
        ref_decode(instr, m, a);
        armed <= 1'b1;
        if (!rst && instr_valid) begin
            exp_valid <= 1'b1;
            exp_main  <= m;
            exp_alu   <= a;
        end else begin
            exp_valid <= 1'b0;
            exp_main  <= '0;
            exp_alu   <= '0;
        end
    end

    always @(negedge clk) begin
        if (armed) begin
            assert (ctrl_valid === exp_valid) else begin
                $display("ERROR %0t: ctrl_valid is %b, expected %b", $time, ctrl_valid, exp_valid);
                errors++;
            end
            assert (main_ctrl === exp_main) else begin
                $display("ERROR %0t: main_ctrl is %h, expected %h", $time, main_ctrl, exp_main);
                errors++;
            end
            assert (alu_ctrl === exp_alu) else begin
                $display("ERROR %0t: alu_ctrl is %h, expected %h", $time, alu_ctrl, exp_alu);
                errors++;
            end
            if (ctrl_valid === 1'b1) begin
                seen++;
            end
        end
    end

    function automatic logic [31:0] random_instr(input int unsigned pick);
        logic [31:0] word;
        word = $random(seed);
        case (pick)
            0: word[6:0] = 7'b0110111;
            1: word[6:0] = 7'b0010111;
            2: word[6:0] = 7'b1101111;
            3: word[6:0] = 7'b1100111;
            4: word[6:0] = 7'b1100011;
            5: word[6:0] = 7'b0000011;
            6: word[6:0] = 7'b0100011;
            7: begin
                word[6:0] = 7'b0010011;
                if (word[14:12] == 3'b001) begin
                    word[31:25] = ctrl_decode_pkg::F7_BASE;   // slli
                end else if (word[14:12] == 3'b101) begin
                    word[31:25] = {1'b0, word[30], 5'b00000}; // srli or srai
                end
            end
            default: begin
                word[6:0] = 7'b0110011;
                case ($unsigned($random(seed)) % 3)
                    0: word[31:25] = ctrl_decode_pkg::F7_BASE;
                    1: word[31:25] = ctrl_decode_pkg::F7_MULDIV;
                    default: begin
                        word[31:25] = ctrl_decode_pkg::F7_ALT;
                        word[14:12] = word[14] ? 3'b101 : 3'b000;  // sub or sra
                    end
                endcase
            end
        endcase
        return word;
    endfunction

    task automatic drive(input logic [31:0] word);
        @(posedge clk);
        instr       <= word;
        instr_valid <= 1'b1;
        sent++;
    endtask

    task automatic idle();
        @(posedge clk);
        instr       <= $random(seed);           // garbage while not valid
        instr_valid <= 1'b0;
    endtask

    task automatic wait_valid(input logic level);
        int cycles;
        cycles = 0;
        do begin
            @(negedge clk);
            cycles++;
        end while (ctrl_valid !== level && cycles < WAIT_LIMIT);
        if (ctrl_valid !== level) begin
            $display("Timeout: ctrl_valid did not go to %b within %0d cycles", level, WAIT_LIMIT);
            timeouts++;
        end
    endtask

    task automatic send_one(input logic [31:0] word);
        drive(word);
        idle();
        wait_valid(1'b1);
        wait_valid(1'b0);
    endtask

    task automatic send_branch(input logic [31:0] word);
        drive(word);
        idle();
        wait_valid(1'b1);
        assert (alu_ctrl.alu_op == ctrl_decode_pkg::SUB && main_ctrl.branch) else begin
            $display("ERROR %0t: branch %h gave alu_op %0d, branch %b",
                     $time, word, alu_ctrl.alu_op, main_ctrl.branch);
            check_errors++;
        end
        wait_valid(1'b0);
    endtask

    initial begin
        rst         <= 1'b1;
        instr_valid <= 1'b0;
        instr       <= '0;
        repeat (10) @(posedge clk);
        rst <= 1'b0;
        for (int k = 0; k < 27; k++) begin
            send_one(random_instr(k % 9));
        end
        for (int i = 0; i < 8; i++) begin
            send_one({7'b0000000, 5'd3, 5'd1, i[2:0], 5'd2, 7'b0010011});
            send_one({ctrl_decode_pkg::F7_BASE, 5'd4, 5'd5, i[2:0], 5'd6, 7'b0110011});
            send_one({ctrl_decode_pkg::F7_ALT, 5'd4, 5'd5, i[2:0], 5'd6, 7'b0110011});
            send_one({ctrl_decode_pkg::F7_MULDIV, 5'd4, 5'd5, i[2:0], 5'd6, 7'b0110011});
            if (i != 2 && i != 3) begin
                send_branch({7'b0101010, 5'd7, 5'd8, i[2:0], 5'd9, 7'b1100011});
            end
        end
        send_one({ctrl_decode_pkg::F7_ALT, 5'd3, 5'd1, 3'b101, 5'd2, 7'b0010011});  // srai
        send_one({25'($random(seed)), 7'b1110011});                                 // system
        send_one({25'h0ff_0000, 7'b0001111});                                        // fence
        send_one({25'h020_3456, 7'b0101111});                                        // amo
        repeat (200) begin
            drive(random_instr($unsigned($random(seed)) % 9));
        end
        idle();
        wait_valid(1'b0);
        repeat (2) idle();
        assert (seen == sent) else begin
            $display("ERROR %0t: %0d instructions sent but %0d results seen", $time, sent, seen);
            check_errors++;
        end
        $display("errors: %0d, timeouts: %0d", errors + check_errors, timeouts);
        if (errors == 0 && check_errors == 0 && timeouts == 0) begin
            $display("Test passed");
        end else begin
            $display("Test failed");
        end
        $finish;
    end

endmodule
`default_nettype wire

// File: compile.f
+incdir+tests
source/ctrl_decode_pkg.sv
source/main_decoder.sv
source/alu_op_decoder.sv
source/control_unit.sv
tests/tb_control_unit.sv

// File: Makefile
# Verilator lint and simulation of the control unit

VERILATOR  := verilator
TB_TOP     := tb_control_unit
RTL_TOP    := control_unit
FILELIST   := compile.f
LINT_FLAGS := --lint-only --timing
SIM_FLAGS  := --binary --timing --assert
OBJ_DIR    := obj_dir
LOG        := sim.log

.PHONY: all lint sim clean

all: sim

lint:
	$(VERILATOR) $(LINT_FLAGS) --top-module $(RTL_TOP) -f $(FILELIST)
	$(VERILATOR) $(LINT_FLAGS) --top-module $(TB_TOP) -f $(FILELIST)

sim:
	$(VERILATOR) $(SIM_FLAGS) --top-module $(TB_TOP) -f $(FILELIST) --Mdir $(OBJ_DIR)
	./$(OBJ_DIR)/V$(TB_TOP) 2>&1 | tee $(LOG)
	@if grep -q "Test failed" $(LOG); then \
		echo "simulation FAILED, see $(LOG)"; exit 1; \
	elif ! grep -q "Test passed" $(LOG); then \
		echo "simulation ended without a result, see $(LOG)"; exit 1; \
	else \
		echo "simulation ok"; \
	fi

clean:
	rm -rf $(OBJ_DIR) $(LOG)
